// ==== Makefile ====
sim:
	verilator --binary -j 0 --timescale 1ns/1ns --top-module tbTop -f decodeExecute.f
	./obj_dir/VtbTop | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== common/pipePkg.sv ====
`default_nettype none

package pipePkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int FUNCT3_W   = 3;
    localparam int OPCODE_W   = 7;

    // Base opcodes plus the custom-0 slot
    localparam logic [OPCODE_W-1:0] OP      = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_IMM  = 7'b0010011;
    localparam logic [OPCODE_W-1:0] LOAD    = 7'b0000011;
    localparam logic [OPCODE_W-1:0] STORE   = 7'b0100011;
    localparam logic [OPCODE_W-1:0] BRANCH  = 7'b1100011;
    localparam logic [OPCODE_W-1:0] JAL     = 7'b1101111;
    localparam logic [OPCODE_W-1:0] LUI     = 7'b0110111;
    localparam logic [OPCODE_W-1:0] CUSTOM0 = 7'b0001011;

    typedef enum logic [1:0] {
        pathAlu,
        pathLink,
        pathImm,
        pathThreshold
    } ExPath;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSlt
    } AluFunc;

    typedef struct packed {
        logic                regWeE;
        logic                regWeW;
        logic                opBSrc;
        logic                memWrite;
        logic                thresholdEnable;
        logic                msWe;
        logic                branch;
        logic                jump;
        ExPath               exPath;
        AluFunc              aluFunc;
        logic [FUNCT3_W-1:0] funct3;
    } ControlWord;

    // Bubble: nothing written, immediate operand, add
    localparam ControlWord ControlNop = '{
        regWeE:          1'b0,
        regWeW:          1'b0,
        opBSrc:          1'b1,
        memWrite:        1'b0,
        thresholdEnable: 1'b0,
        msWe:            1'b0,
        branch:          1'b0,
        jump:            1'b0,
        exPath:          pathAlu,
        aluFunc:         aluAdd,
        funct3:          '0
    };

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rs1Data;
        logic [XLEN-1:0]       rs2Data;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
    } OperandWord;

    localparam OperandWord OperandNop = '0;

    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] rd;
        logic                  regWeE;
        logic                  regWeW;
        logic                  memWrite;
        logic                  thresholdEnable;
        logic                  msWe;
    } ExecuteResult;

endpackage

`default_nettype wire

// ==== decodeExecute.f ====
common/pipePkg.sv
source/controlDecoder.sv
source/pipeStage.sv
source/hazardUnit.sv
execute/executeUnit.sv
source/decodeExecuteTop.sv
verif/clockGen.sv
verif/resultMonitor.sv
verif/tbTop.sv

// ==== execute/executeUnit.sv ====
`default_nettype none

module executeUnit import pipePkg::*; (
    input  ControlWord      ctrlE,
    input  OperandWord      opsE,
    output ExecuteResult    res,
    output logic            branchTaken,
    output logic [XLEN-1:0] branchTarget
);

    logic [XLEN-1:0] opA;
    logic [XLEN-1:0] opB;
    logic [XLEN-1:0] aluOut;
    logic [XLEN-1:0] thresholdOut;
    logic [XLEN-1:0] linkAddr;
    logic [XLEN-1:0] resultMux;
    logic            branchCond;
    logic            eq;
    logic            ltSigned;
    logic            ltUnsigned;

    assign opA = opsE.rs1Data;
    assign opB = ctrlE.opBSrc ? opsE.imm : opsE.rs2Data;

    always_comb begin
        case (ctrlE.aluFunc)
            aluAdd:  aluOut = opA + opB;
            aluSub:  aluOut = opA - opB;
            aluAnd:  aluOut = opA & opB;
            aluOr:   aluOut = opA | opB;
            aluXor:  aluOut = opA ^ opB;
            aluSll:  aluOut = opA << opB[4:0];
            aluSrl:  aluOut = opA >> opB[4:0];
            default: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
        endcase
    end

    // 1 when rs1 is above the threshold
    assign thresholdOut = {{(XLEN-1){1'b0}}, opA > opB};
    assign linkAddr     = opsE.pc + 32'd4;

    always_comb begin
        case (ctrlE.exPath)
            pathAlu:       resultMux = aluOut;
            pathLink:      resultMux = linkAddr;
            pathImm:       resultMux = opsE.imm;
            default:       resultMux = thresholdOut;
        endcase
    end

    // Branches compare the two register operands directly
    assign eq         = opsE.rs1Data == opsE.rs2Data;
    assign ltSigned   = $signed(opsE.rs1Data) < $signed(opsE.rs2Data);
    assign ltUnsigned = opsE.rs1Data < opsE.rs2Data;

    always_comb begin
        case (ctrlE.funct3)
            3'b000:  branchCond = eq;
            3'b001:  branchCond = !eq;
            3'b100:  branchCond = ltSigned;
            3'b101:  branchCond = !ltSigned;
            3'b110:  branchCond = ltUnsigned;
            3'b111:  branchCond = !ltUnsigned;
            default: branchCond = 1'b0;
        endcase
    end

    assign branchTaken  = ctrlE.jump || (ctrlE.branch && branchCond);
    assign branchTarget = opsE.pc + opsE.imm;

    assign res.result          = resultMux;
    assign res.storeData       = opsE.rs2Data;
    assign res.rd              = opsE.rd;
    assign res.regWeE          = ctrlE.regWeE;
    assign res.regWeW          = ctrlE.regWeW;
    assign res.memWrite        = ctrlE.memWrite;
    assign res.thresholdEnable = ctrlE.thresholdEnable;
    assign res.msWe            = ctrlE.msWe;

endmodule

`default_nettype wire

// ==== source/controlDecoder.sv ====
`default_nettype none

module controlDecoder import pipePkg::*; (
    input  logic [XLEN-1:0] instr,
    output ControlWord      ctrl,
    output logic [XLEN-1:0] imm
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                altBit;
    logic [XLEN-1:0]     immI;
    logic [XLEN-1:0]     immS;
    logic [XLEN-1:0]     immB;
    logic [XLEN-1:0]     immJ;
    logic [XLEN-1:0]     immU;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    // funct7 bit 5 separates add from sub
    assign altBit = instr[30];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign immU = {instr[31:12], 12'b0};

    function automatic AluFunc aluFromFunct3(
        input logic [FUNCT3_W-1:0] f3,
        input logic                useSub
    );
        AluFunc func;
        case (f3)
            3'b000:  func = useSub ? aluSub : aluAdd;
            3'b001:  func = aluSll;
            3'b010:  func = aluSlt;
            3'b011:  func = aluSlt;
            3'b100:  func = aluXor;
            3'b101:  func = aluSrl;
            3'b110:  func = aluOr;
            default: func = aluAnd;
        endcase
        return func;
    endfunction

    always_comb begin
        ctrl = ControlNop;
        imm  = immI;
        case (opcode)
            OP: begin
                ctrl.regWeE  = 1'b1;
                ctrl.opBSrc  = 1'b0;
                ctrl.aluFunc = aluFromFunct3(funct3, altBit);
                ctrl.funct3  = funct3;
            end
            OP_IMM: begin
                // No subtract form for immediates
                ctrl.regWeE  = 1'b1;
                ctrl.aluFunc = aluFromFunct3(funct3, 1'b0);
                ctrl.funct3  = funct3;
            end
            LOAD: begin
                ctrl.regWeW = 1'b1;
                ctrl.funct3 = funct3;
            end
            STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.funct3   = funct3;
                imm           = immS;
            end
            BRANCH: begin
                ctrl.branch  = 1'b1;
                ctrl.opBSrc  = 1'b0;
                ctrl.aluFunc = aluSub;
                ctrl.funct3  = funct3;
                imm          = immB;
            end
            JAL: begin
                ctrl.regWeE = 1'b1;
                ctrl.jump   = 1'b1;
                ctrl.exPath = pathLink;
                imm         = immJ;
            end
            LUI: begin
                ctrl.regWeE = 1'b1;
                ctrl.exPath = pathImm;
                imm         = immU;
            end
            CUSTOM0: begin
                if (funct3 == 3'b000) begin
                    // Compare rs1 against the immediate threshold
                    ctrl.regWeE          = 1'b1;
                    ctrl.thresholdEnable = 1'b1;
                    ctrl.exPath          = pathThreshold;
                    ctrl.funct3          = funct3;
                end else if (funct3 == 3'b001) begin
                    // Status value is rs1 + imm, written by a later stage
                    ctrl.msWe   = 1'b1;
                    ctrl.funct3 = funct3;
                end
            end
            default: begin
                ctrl = ControlNop;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/decodeExecuteTop.sv ====
`default_nettype none

module decodeExecuteTop import pipePkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    input  logic            memStall,
    output ExecuteResult    res,
    output logic            branchTaken,
    output logic [XLEN-1:0] branchTarget,
    output logic            stallD,
    output logic            flushD
);

    ControlWord      ctrlD;
    ControlWord      ctrlE;
    OperandWord      opsD;
    OperandWord      opsE;
    logic [XLEN-1:0] immD;
    logic            stallE;
    logic            flushE;

    controlDecoder decoder (
        .instr (instr),
        .ctrl  (ctrlD),
        .imm   (immD)
    );

    assign opsD.pc      = pc;
    assign opsD.rs1Data = rs1Data;
    assign opsD.rs2Data = rs2Data;
    assign opsD.imm     = immD;
    assign opsD.rs1     = instr[19:15];
    assign opsD.rs2     = instr[24:20];
    assign opsD.rd      = instr[11:7];

    pipeStage #(.payloadT(ControlWord), .nopValue(ControlNop)) ctrlStage (
        .clk   (clk),
        .reset (reset),
        .stall (stallE),
        .flush (flushE),
        .d     (ctrlD),
        .q     (ctrlE)
    );

    pipeStage #(.payloadT(OperandWord), .nopValue(OperandNop)) opsStage (
        .clk   (clk),
        .reset (reset),
        .stall (stallE),
        .flush (flushE),
        .d     (opsD),
        .q     (opsE)
    );

    hazardUnit hazards (
        .rs1D        (opsD.rs1),
        .rs2D        (opsD.rs2),
        .rdE         (opsE.rd),
        .regWeWE     (ctrlE.regWeW),
        .branchTaken (branchTaken),
        .memStall    (memStall),
        .stallD      (stallD),
        .flushD      (flushD),
        .stallE      (stallE),
        .flushE      (flushE)
    );

    executeUnit execute (
        .ctrlE        (ctrlE),
        .opsE         (opsE),
        .res          (res),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

endmodule

`default_nettype wire

// ==== source/hazardUnit.sv ====
`default_nettype none

module hazardUnit import pipePkg::*; (
    input  logic [REG_ADDR_W-1:0] rs1D,
    input  logic [REG_ADDR_W-1:0] rs2D,
    input  logic [REG_ADDR_W-1:0] rdE,
    input  logic                  regWeWE,
    input  logic                  branchTaken,
    input  logic                  memStall,
    output logic                  stallD,
    output logic                  flushD,
    output logic                  stallE,
    output logic                  flushE
);

    logic loadUse;
    logic rdMatch;

    assign rdMatch = (rdE == rs1D) || (rdE == rs2D);

    // Load in E feeds the instruction waiting in D, x0 never conflicts
    assign loadUse = regWeWE && (rdE != '0) && rdMatch;

    assign stallE = memStall;
    assign stallD = memStall || loadUse;

    // Flushes wait for memory so a held instruction is not lost
    assign flushD = branchTaken && !memStall;
    assign flushE = (loadUse || branchTaken) && !memStall;

endmodule

`default_nettype wire

// ==== source/pipeStage.sv ====
`default_nettype none

// One pipeline register for any packed payload
module pipeStage #(
    parameter type     payloadT = logic,
    parameter payloadT nopValue = '0
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q <= nopValue;
        end else if (flush) begin
            // Flush wins over stall
            q <= nopValue;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== verif/clockGen.sv ====
`default_nettype none

module clockGen (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ns;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Held for eight rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/resultMonitor.sv ====
`default_nettype none

module resultMonitor import pipePkg::*; (
    input  logic            clk,
    input  logic            reset,
    input  int              testId,
    input  logic [XLEN-1:0] instr,
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] rs1Data,
    input  logic [XLEN-1:0] rs2Data,
    input  logic            memStall,
    input  ExecuteResult    res,
    input  logic            branchTaken,
    input  logic [XLEN-1:0] branchTarget,
    input  logic            stallD,
    input  logic            flushD,
    output int              checkCount,
    output int              errorCount
);

    timeunit 1ns;
    timeprecision 1ns;

    // Instruction word as presented at D, with its operands
    typedef struct packed {
        logic [XLEN-1:0] word;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } Issued;

    typedef struct packed {
        ExecuteResult    res;
        logic            taken;
        logic [XLEN-1:0] target;
    } Predicted;

    Issued           inE = '0;
    Predicted        predicted;
    logic            loadUse;
    logic [4:0]      rdE;
    logic [34:0]     expCtl;
    logic [34:0]     actCtl;
    int              currentId = 0;
    int              testChecks = 0;
    int              testErrors = 0;
    int              checks = 0;
    int              errors = 0;

    assign checkCount = checks;
    assign errorCount = errors;

    function automatic logic [XLEN-1:0] aluModel(
        input logic [2:0]      f3,
        input logic            sub,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b100:  return a ^ b;
            3'b101:  return a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(
        input logic [2:0]      f3,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic Predicted reference(input Issued i);
        Predicted        p;
        logic [2:0]      f3;
        logic [XLEN-1:0] immI;
        logic [XLEN-1:0] immS;
        logic [XLEN-1:0] immB;
        logic [XLEN-1:0] immJ;
        f3   = i.word[14:12];
        immI = {{20{i.word[31]}}, i.word[31:20]};
        immS = {{20{i.word[31]}}, i.word[31:25], i.word[11:7]};
        immB = {{20{i.word[31]}}, i.word[7], i.word[30:25], i.word[11:8], 1'b0};
        immJ = {{12{i.word[31]}}, i.word[19:12], i.word[20], i.word[30:21], 1'b0};
        p = '0;
        p.res.storeData = i.b;
        p.res.rd        = i.word[11:7];
        // NOP control still adds rs1 and the I immediate
        p.res.result    = i.a + immI;
        case (i.word[6:0])
            OP: begin
                p.res.regWeE = 1'b1;
                p.res.result = aluModel(f3, i.word[30], i.a, i.b);
            end
            OP_IMM: begin
                p.res.regWeE = 1'b1;
                p.res.result = aluModel(f3, 1'b0, i.a, immI);
            end
            LOAD: p.res.regWeW = 1'b1;
            STORE: begin
                p.res.memWrite = 1'b1;
                p.res.result   = i.a + immS;
            end
            BRANCH: begin
                p.res.result = i.a - i.b;
                p.taken      = branchModel(f3, i.a, i.b);
                p.target     = i.pc + immB;
            end
            JAL: begin
                p.res.regWeE = 1'b1;
                p.res.result = i.pc + 32'd4;
                p.taken      = 1'b1;
                p.target     = i.pc + immJ;
            end
            LUI: begin
                p.res.regWeE = 1'b1;
                p.res.result = {i.word[31:12], 12'b0};
            end
            CUSTOM0: begin
                if (f3 == 3'b000) begin
                    p.res.regWeE          = 1'b1;
                    p.res.thresholdEnable = 1'b1;
                    p.res.result          = {31'b0, i.a > immI};
                end else if (f3 == 3'b001) begin
                    p.res.msWe = 1'b1;
                end
            end
            default: ;
        endcase
        return p;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1:       return "reset";
            2:       return "arithmetic";
            3:       return "branch";
            4:       return "loadUse";
            default: return "memStall";
        endcase
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            inE = '0;
        end
        predicted = reference(inE);
        rdE       = inE.word[11:7];
        loadUse   = (inE.word[6:0] == LOAD) && (rdE != 5'd0)
                    && (rdE == instr[19:15] || rdE == instr[24:20]);
        if (testId != currentId) begin
            if (currentId != 0) begin
                $display("%s: %0d checks, %0d errors", testName(currentId), testChecks,
                         testErrors);
            end
            currentId  = testId;
            testChecks = 0;
            testErrors = 0;
        end
        // Target only matters when the branch is taken
        expCtl = {predicted.taken, predicted.taken ? predicted.target : 32'b0,
                  memStall || loadUse, predicted.taken && !memStall};
        actCtl = {branchTaken, branchTaken ? branchTarget : 32'b0, stallD, flushD};
        checks++;
        testChecks++;
        if (res !== predicted.res) begin
            $display("Fail %s at %0t: result expected %h actual %h", testName(currentId),
                     $time, predicted.res, res);
            errors++;
            testErrors++;
        end
        if (actCtl !== expCtl) begin
            $display("Fail %s at %0t: taken/target/stallD/flushD expected %h actual %h",
                     testName(currentId), $time, expCtl, actCtl);
            errors++;
            testErrors++;
        end
        // E holds under memory stall, takes a bubble on load-use or taken branch
        if (!reset && !memStall) begin
            if (loadUse || predicted.taken) begin
                inE = '0;
            end else begin
                inE = {instr, pc, rs1Data, rs2Data};
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/tbTop.sv ====
`default_nettype none

module tbTop import pipePkg::*; ();

    timeunit 1ns;
    timeprecision 1ns;

    localparam int ACCEPT_LIMIT = 6;
    localparam int RESET_LIMIT  = 20;

    logic            clk;
    logic            reset;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1Data;
    logic [XLEN-1:0] rs2Data;
    logic            memStall;
    ExecuteResult    res;
    logic            branchTaken;
    logic [XLEN-1:0] branchTarget;
    logic            stallD;
    logic            flushD;
    int              testId;
    int              checkCount;
    int              errorCount;
    logic [31:0]     rngState;
    logic [31:0]     pcNext;
    logic            timedOut;

    clockGen clocks (
        .clk   (clk),
        .reset (reset)
    );

    decodeExecuteTop UUT (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .pc           (pc),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .memStall     (memStall),
        .res          (res),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .stallD       (stallD),
        .flushD       (flushD)
    );

    resultMonitor monitor (
        .clk          (clk),
        .reset        (reset),
        .testId       (testId),
        .instr        (instr),
        .pc           (pc),
        .rs1Data      (rs1Data),
        .rs2Data      (rs2Data),
        .memStall     (memStall),
        .res          (res),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .stallD       (stallD),
        .flushD       (flushD),
        .checkCount   (checkCount),
        .errorCount   (errorCount)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic nextRand(output logic [31:0] value);
        rngState = xorshift(rngState);
        value    = rngState;
    endtask

    // Kinds: OP, OP_IMM, LUI, STORE, CUSTOM0, BRANCH, JAL, LOAD
    task automatic randomInstr(input int kind, output logic [31:0] word);
        logic [31:0] r;
        logic [2:0]  f3;
        nextRand(r);
        word = r;
        f3   = r[14:12];
        case (kind)
            0: begin
                word[6:0] = OP;
                if (f3 == 3'd3) f3 = 3'd2;
                // funct7 is zero apart from the sub bit
                word[31:25] = {1'b0, r[30] && (f3 == 3'd0), 5'b0};
            end
            1: begin
                word[6:0] = OP_IMM;
                if (f3 == 3'd3) f3 = 3'd2;
            end
            2: word[6:0] = LUI;
            3: word[6:0] = STORE;
            4: begin
                word[6:0] = CUSTOM0;
                f3        = {2'b00, r[12]};
            end
            5: begin
                word[6:0] = BRANCH;
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
            end
            6: word[6:0] = JAL;
            default: word[6:0] = LOAD;
        endcase
        word[14:12] = f3;
    endtask

    task automatic idle(input int cycles);
        instr    = '0;
        pc       = '0;
        rs1Data  = '0;
        rs2Data  = '0;
        memStall = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    // Drive one instruction and hold it until D accepts it
    task automatic issue(input logic [31:0] word, input int stallCycles);
        logic [31:0] a;
        logic [31:0] b;
        int          waited;
        logic        accepted;
        nextRand(a);
        nextRand(b);
        // Equal operands now and then so beq and bge take
        if (b[31:30] == 2'b00) b = a;
        instr    = word;
        pc       = pcNext;
        rs1Data  = a;
        rs2Data  = b;
        memStall = (stallCycles > 0);
        waited   = 0;
        accepted = 1'b0;
        while (!accepted && !timedOut && waited <= stallCycles + ACCEPT_LIMIT) begin
            @(posedge clk);
            accepted = !stallD;
            @(negedge clk);
            waited++;
            if (waited >= stallCycles) memStall = 1'b0;
        end
        if (!accepted && !timedOut) begin
            $display("Timeout: instruction %h at pc %h was never accepted", word, pcNext);
            timedOut = 1'b1;
        end
        pcNext = pcNext + 32'd4;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        logic [31:0] load;
        logic [31:0] dep;
        int          waited;
        rngState = 32'h8af3ae6f;
        timedOut = 1'b0;
        testId   = 1;
        idle(1);
        nextRand(pcNext);
        pcNext[1:0] = 2'b00;
        waited = 0;
        while (reset && waited < RESET_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (reset) begin
            $display("Timeout: reset was never released");
            timedOut = 1'b1;
        end
        idle(4);

        testId = 2;
        repeat (60) begin
            nextRand(r);
            randomInstr(int'(r % 32'd5), word);
            issue(word, 0);
        end
        idle(2);

        testId = 3;
        repeat (40) begin
            nextRand(r);
            randomInstr(r[1] ? (r[0] ? 6 : 5) : 0, word);
            issue(word, 0);
        end
        idle(2);

        testId = 4;
        repeat (16) begin
            nextRand(r);
            randomInstr(7, load);
            if (load[11:7] == 5'd0) load[11:7] = 5'd1;
            randomInstr(int'(r % 32'd2), dep);
            if (r[2]) dep[19:15] = load[11:7];
            else if (r[3]) dep[24:20] = load[11:7];
            issue(load, 0);
            issue(dep, 0);
        end
        idle(2);

        testId = 5;
        repeat (30) begin
            nextRand(r);
            randomInstr(int'(r[2:0]), word);
            issue(word, r[3] ? int'(r[6:4]) + 1 : 0);
        end
        idle(3);
        testId = 0;
        idle(2);

        $display("Tests run: 5, checks: %0d, errors: %0d", checkCount, errorCount);
        if (!timedOut && errorCount == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
